// ==== Makefile ====
# Verilator flow for the RV32I execute engine
TOP = tb_rv_exec

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module rv_exec_top

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

// ==== filelist.f ====
+incdir+rtl
+incdir+tb
rtl/rv_exec_pkg.sv
rtl/rv_decoder.sv
rtl/rv_alu.sv
rtl/rv_regfile.sv
rtl/rv_pc_counter.sv
rtl/rv_control_fsm.sv
rtl/rv_exec_top.sv
tb/tb_rv_exec.sv

// ==== rtl/rv_alu.sv ====
// ======================================================================
// RV32I arithmetic logic unit
// Operand bypass muxes and the registered ALU result
// ======================================================================
`include "rv_exec_macros.svh"

module rv_alu (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    exe_en,     // Result capture strobe
    input  rv_exec_pkg::dec_ctrl_t  ctrl,
    input  logic [`RV_XLEN-1:0]     pc,
    input  logic [`RV_XLEN-1:0]     rs1_data,
    input  logic [`RV_XLEN-1:0]     rs2_data,
    output logic [`RV_XLEN-1:0]     result
);
    import rv_exec_pkg::*;

    logic [`RV_XLEN-1:0] operand_1;
    logic [`RV_XLEN-1:0] operand_2;
    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] alu_res;

    always_comb begin
        case (ctrl.op1_sel)
            OP1_PC:  operand_1 = pc;                // AUIPC, JAL, JALR
            default: operand_1 = rs1_data;
        endcase
    end

    always_comb begin
        case (ctrl.op2_sel)
            OP2_IMM:  operand_2 = ctrl.imm;
            OP2_LINK: operand_2 = `RV_LINK_OFFSET;  // PC + 4 link address
            default:  operand_2 = rs2_data;
        endcase
    end

    assign shamt = operand_2[4:0];                  // Only low 5 bits shift

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:  alu_res = operand_1 + operand_2;
            ALU_SUB:  alu_res = operand_1 - operand_2;     // Wraps on underflow
            ALU_SLL:  alu_res = operand_1 << shamt;
            ALU_SLT:  alu_res = {31'b0, $signed(operand_1) < $signed(operand_2)};
            ALU_SLTU: alu_res = {31'b0, operand_1 < operand_2};
            ALU_XOR:  alu_res = operand_1 ^ operand_2;
            ALU_SRL:  alu_res = operand_1 >> shamt;
            ALU_SRA:  alu_res = $unsigned($signed(operand_1) >>> shamt);
            ALU_OR:   alu_res = operand_1 | operand_2;
            ALU_AND:  alu_res = operand_1 & operand_2;
            default:  alu_res = '0;                 // ALU_NONE yields zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result <= '0;
        end else if (exe_en) begin
            result <= alu_res;
        end
    end

    // Decoder and regfile must deliver known operands by the capture edge
    a_result_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        exe_en |=> !$isunknown(result)
    );

endmodule

// ==== rtl/rv_control_fsm.sv ====
// ======================================================================
// Execute sequencer
// Idle, decode, execute and retire states with stage enables
// ======================================================================

module rv_control_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic instr_valid,       // Host strobe, only while idle
    output logic dec_en,
    output logic exe_en,
    output logic wb_en,
    output logic busy,
    output logic retire_valid
);
    import rv_exec_pkg::*;

    state_t state;
    state_t state_nxt;

    always_comb begin
        case (state)
            ST_IDLE:   state_nxt = instr_valid ? ST_DECODE : ST_IDLE;
            ST_DECODE: state_nxt = ST_EXEC;
            ST_EXEC:   state_nxt = ST_RETIRE;
            default:   state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            retire_valid <= 1'b0;
        end else begin
            state        <= state_nxt;
            retire_valid <= (state == ST_RETIRE);   // Pulse as busy drops
        end
    end

    assign dec_en = instr_valid && (state == ST_IDLE);  // Strobes while busy ignored
    assign exe_en = (state == ST_DECODE);
    assign wb_en  = (state == ST_EXEC);
    assign busy   = (state != ST_IDLE);

    // Host protocol, no strobe during an instruction
    a_no_strobe_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        instr_valid |-> !busy
    );

    a_retire_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        retire_valid |=> !retire_valid
    );

endmodule

// ==== rtl/rv_decoder.sv ====
// ======================================================================
// RV32I instruction decoder
// Instruction register, immediates, ALU op and operand select decode
// ======================================================================
`include "rv_exec_macros.svh"

module rv_decoder (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    dec_en,     // Accept strobe from FSM
    input  logic [31:0]             instr,
    output rv_exec_pkg::dec_ctrl_t  ctrl
);
    import rv_exec_pkg::*;

    localparam logic [31:0] NOP = 32'h0000_0013;   // ADDI x0, x0, 0

    logic [31:0]         instr_q;
    opcode_t             opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            instr_q <= NOP;
        end else if (dec_en) begin
            instr_q <= instr;
        end
    end

    assign opcode = opcode_t'(instr_q[6:0]);
    assign funct3 = instr_q[14:12];
    assign funct7 = instr_q[31:25];

    assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};        // Also carries shamt
    assign imm_u = {instr_q[31:12], 12'b0};
    assign imm_j = {{12{instr_q[31]}}, instr_q[19:12], instr_q[20],
                    instr_q[30:21], 1'b0};

    always_comb begin
        ctrl           = '0;
        ctrl.alu_op    = ALU_NONE;                  // Stays NONE unless decoded
        ctrl.op1_sel   = OP1_RS1;
        ctrl.op2_sel   = OP2_RS2;
        ctrl.jump      = JMP_NONE;
        ctrl.rd        = instr_q[11:7];
        ctrl.rs1       = instr_q[19:15];
        ctrl.rs2       = instr_q[24:20];
        ctrl.imm       = imm_i;
        ctrl.reg_write = 1'b1;
        ctrl.illegal   = 1'b0;
        case (opcode)
            OPC_OP_IMM: begin
                ctrl.op2_sel = OP2_IMM;
                case (funct3)
                    3'b000: ctrl.alu_op = ALU_ADD;
                    3'b010: ctrl.alu_op = ALU_SLT;
                    3'b011: ctrl.alu_op = ALU_SLTU;
                    3'b100: ctrl.alu_op = ALU_XOR;
                    3'b110: ctrl.alu_op = ALU_OR;
                    3'b111: ctrl.alu_op = ALU_AND;
                    3'b001: begin
                        if (funct7 == 7'b0000000) ctrl.alu_op = ALU_SLL;
                        else                      ctrl.illegal = 1'b1;
                    end
                    default: begin                  // 3'b101, SRLI or SRAI
                        if (funct7 == 7'b0000000)      ctrl.alu_op = ALU_SRL;
                        else if (funct7 == 7'b0100000) ctrl.alu_op = ALU_SRA;
                        else                           ctrl.illegal = 1'b1;
                    end
                endcase
            end
            OPC_OP: begin
                case ({funct7, funct3})
                    10'b0000000_000: ctrl.alu_op = ALU_ADD;
                    10'b0100000_000: ctrl.alu_op = ALU_SUB;
                    10'b0000000_001: ctrl.alu_op = ALU_SLL;
                    10'b0000000_010: ctrl.alu_op = ALU_SLT;
                    10'b0000000_011: ctrl.alu_op = ALU_SLTU;
                    10'b0000000_100: ctrl.alu_op = ALU_XOR;
                    10'b0000000_101: ctrl.alu_op = ALU_SRL;
                    10'b0100000_101: ctrl.alu_op = ALU_SRA;
                    10'b0000000_110: ctrl.alu_op = ALU_OR;
                    10'b0000000_111: ctrl.alu_op = ALU_AND;
                    default:         ctrl.illegal = 1'b1;
                endcase
            end
            OPC_AUIPC: begin
                ctrl.alu_op  = ALU_ADD;             // PC + upper immediate
                ctrl.op1_sel = OP1_PC;
                ctrl.op2_sel = OP2_IMM;
                ctrl.imm     = imm_u;
            end
            OPC_JAL: begin
                ctrl.alu_op  = ALU_ADD;             // Link value PC + 4
                ctrl.op1_sel = OP1_PC;
                ctrl.op2_sel = OP2_LINK;
                ctrl.jump    = JMP_PC_REL;
                ctrl.imm     = imm_j;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    ctrl.alu_op  = ALU_ADD;
                    ctrl.op1_sel = OP1_PC;
                    ctrl.op2_sel = OP2_LINK;
                    ctrl.jump    = JMP_REG;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            default: ctrl.illegal = 1'b1;           // Unknown opcode
        endcase
        if (ctrl.illegal || ctrl.rd == 5'd0) begin
            ctrl.reg_write = 1'b0;                  // No write for x0 or illegal
        end
    end

endmodule

// ==== rtl/rv_exec_macros.svh ====
// ======================================================================
// RV32I execute engine parameters
// Word width, register count, reset PC and link offset
// ======================================================================
`ifndef RV_EXEC_MACROS_SVH
`define RV_EXEC_MACROS_SVH

// Integer register width, RV32I
`define RV_XLEN 32

// Architectural registers x0 to x31
`define RV_NREGS 32

// Program counter value after reset
`define RV_RESET_PC 32'h0000_0000

// Constant second operand used to form JAL and JALR link addresses
`define RV_LINK_OFFSET 32'd4

`endif

// ==== rtl/rv_exec_pkg.sv ====
// ======================================================================
// RV32I execute engine types
// Opcodes, ALU operations, mux selects, FSM states and records
// ======================================================================
`include "rv_exec_macros.svh"

package rv_exec_pkg;

    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,            // ADDI .. SRAI
        OPC_OP     = 7'b0110011,            // ADD .. AND
        OPC_AUIPC  = 7'b0010111,            // Own opcode, not shared with OP-IMM
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9,
        ALU_NONE = 4'd15                    // Illegal, result forced to zero
    } alu_op_t;

    typedef enum logic {
        OP1_RS1 = 1'b0,
        OP1_PC  = 1'b1
    } op1_sel_t;

    typedef enum logic [1:0] {
        OP2_RS2  = 2'b00,
        OP2_IMM  = 2'b01,
        OP2_LINK = 2'b10                    // Constant link offset
    } op2_sel_t;

    typedef enum logic [1:0] {
        JMP_NONE   = 2'b00,                 // Sequential PC+4
        JMP_PC_REL = 2'b01,                 // JAL
        JMP_REG    = 2'b10                  // JALR
    } jump_t;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'b00,
        ST_DECODE = 2'b01,
        ST_EXEC   = 2'b10,
        ST_RETIRE = 2'b11
    } state_t;

    typedef struct packed {
        alu_op_t              alu_op;
        op1_sel_t             op1_sel;
        op2_sel_t             op2_sel;
        jump_t                jump;
        logic [4:0]           rd;
        logic [4:0]           rs1;
        logic [4:0]           rs2;
        logic [`RV_XLEN-1:0]  imm;          // Sign-extended I, U or J immediate
        logic                 reg_write;    // Clear for rd == x0 and illegal
        logic                 illegal;
    } dec_ctrl_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]  pc;
        logic [`RV_XLEN-1:0]  next_pc;
        logic [4:0]           rd;
        logic [`RV_XLEN-1:0]  rd_data;
        logic                 reg_write;
        logic                 illegal;
    } retire_t;

endpackage

// ==== rtl/rv_exec_top.sv ====
// ======================================================================
// RV32I execute engine top level
// Sequencer, decoder, regfile, ALU, PC and the retire record
// ======================================================================
`include "rv_exec_macros.svh"

module rv_exec_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  instr_valid,
    input  logic [31:0]           instr,
    output logic                  busy,
    output logic                  retire_valid,
    output rv_exec_pkg::retire_t  retire
);
    import rv_exec_pkg::*;

    logic                dec_en;
    logic                exe_en;
    logic                wb_en;
    dec_ctrl_t           ctrl;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] result;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] next_pc;

    rv_control_fsm u_fsm (
        .clk, .rst_n, .instr_valid,
        .dec_en, .exe_en, .wb_en, .busy, .retire_valid
    );

    rv_decoder u_dec (
        .clk, .rst_n, .dec_en, .instr, .ctrl
    );

    rv_regfile u_rf (
        .clk, .rst_n,
        .we       (wb_en && ctrl.reg_write),    // x0 and illegal already masked
        .rs1_addr (ctrl.rs1),
        .rs2_addr (ctrl.rs2),
        .rd_addr  (ctrl.rd),
        .rd_data  (result),
        .rs1_data, .rs2_data
    );

    rv_alu u_alu (
        .clk, .rst_n, .exe_en, .ctrl, .pc, .rs1_data, .rs2_data, .result
    );

    rv_pc_counter u_pc (
        .clk, .rst_n, .exe_en, .wb_en,
        .jump (ctrl.jump),
        .imm  (ctrl.imm),
        .rs1_data, .pc, .next_pc
    );

    // Captured with the commit edge, held while retire_valid pulses
    always_ff @(posedge clk) begin
        if (wb_en) begin
            retire.pc        <= pc;                 // Old PC, updated same edge
            retire.next_pc   <= next_pc;
            retire.rd        <= ctrl.rd;
            retire.rd_data   <= result;
            retire.reg_write <= ctrl.reg_write;
            retire.illegal   <= ctrl.illegal;
        end
    end

endmodule

// ==== rtl/rv_pc_counter.sv ====
// ======================================================================
// Program counter
// Computes the next PC on execute and loads it on write-back
// ======================================================================
`include "rv_exec_macros.svh"

module rv_pc_counter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 exe_en,    // Capture next PC
    input  logic                 wb_en,     // Commit next PC
    input  rv_exec_pkg::jump_t   jump,
    input  logic [`RV_XLEN-1:0]  imm,
    input  logic [`RV_XLEN-1:0]  rs1_data,
    output logic [`RV_XLEN-1:0]  pc,
    output logic [`RV_XLEN-1:0]  next_pc
);
    import rv_exec_pkg::*;

    logic [`RV_XLEN-1:0] target;

    always_comb begin
        case (jump)
            JMP_PC_REL: target = pc + imm;                          // JAL
            JMP_REG:    target = (rs1_data + imm) & ~`RV_XLEN'(1);  // JALR, bit 0 cleared
            default:    target = pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc      <= `RV_RESET_PC;
            next_pc <= `RV_RESET_PC + 32'd4;
        end else begin
            if (exe_en) next_pc <= target;
            if (wb_en)  pc      <= next_pc;
        end
    end

    // Targets from the decoder immediates and the regfile stay word aligned
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00
    );

endmodule

// ==== rtl/rv_regfile.sv ====
// ======================================================================
// RV32I integer register file
// Two asynchronous reads, one synchronous write, x0 reads zero
// ======================================================================
`include "rv_exec_macros.svh"

module rv_regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                we,         // Write-back strobe
    input  logic [4:0]          rs1_addr,
    input  logic [4:0]          rs2_addr,
    input  logic [4:0]          rd_addr,
    input  logic [`RV_XLEN-1:0] rd_data,
    output logic [`RV_XLEN-1:0] rs1_data,
    output logic [`RV_XLEN-1:0] rs2_data
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;                      // All registers start at zero
            end
        end else if (we && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // Entry 0 is hardwired, whatever the array holds
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// ==== tb/rv_ref_model.svh ====
// ======================================================================
// Reference model for the RV32I execute engine
// Shadow registers and PC, instruction encoders, one-step execution
// ======================================================================
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

logic [`RV_XLEN-1:0] shadow_regs [`RV_NREGS] = '{default: '0};  // x0 never written
logic [`RV_XLEN-1:0] shadow_pc = `RV_RESET_PC;

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};             // Shift forms carry funct7 in imm
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OPC_AUIPC};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

// Integer result by funct3, alt selects SUB or arithmetic right shift
function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
                                      input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};  // Sign first
        3'd3:    return {31'b0, a < b};
        3'd4:    return a ^ b;
        3'd5:    return alt ? (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]))
                            : a >> b[4:0];   // Fill vacated bits with sign
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic retire_t reference_step(input logic [31:0] w);
    retire_t             r;
    logic [`RV_XLEN-1:0] a;
    logic [`RV_XLEN-1:0] imm;
    logic [2:0]          f3;
    logic [6:0]          f7;
    logic                bad;
    a         = shadow_regs[w[19:15]];        // Read before any write, as for JALR
    imm       = {{20{w[31]}}, w[31:20]};
    f3        = w[14:12];
    f7        = w[31:25];
    bad       = 1'b0;
    r.pc      = shadow_pc;
    r.next_pc = shadow_pc + 32'd4;
    r.rd      = w[11:7];
    r.rd_data = '0;
    case (w[6:0])
        OPC_OP: begin
            bad       = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
            r.rd_data = arith(f3, f7[5], a, shadow_regs[w[24:20]]);
        end
        OPC_OP_IMM: begin
            if (f3 == 3'd1) bad = (f7 != 7'h00);
            if (f3 == 3'd5) bad = (f7 != 7'h00 && f7 != 7'h20);
            r.rd_data = arith(f3, f3 == 3'd5 && f7[5], a, imm);  // ADDI never subtracts
        end
        OPC_AUIPC: r.rd_data = shadow_pc + {w[31:12], 12'b0};
        OPC_JAL: begin
            r.rd_data = shadow_pc + 32'd4;      // Link value
            r.next_pc = shadow_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        OPC_JALR: begin
            bad       = (f3 != 3'd0);
            r.rd_data = shadow_pc + 32'd4;
            if (!bad) r.next_pc = (a + imm) & ~32'd1;
        end
        default: bad = 1'b1;                    // Unsupported opcode
    endcase
    if (bad) r.rd_data = '0;
    r.illegal   = bad;
    r.reg_write = !bad && (w[11:7] != 5'd0);
    if (r.reg_write) shadow_regs[w[11:7]] = r.rd_data;
    shadow_pc = r.next_pc;
    return r;
endfunction

`endif

// ==== tb/tb_rv_exec.sv ====
// ======================================================================
// Testbench for the RV32I execute engine
// Directed, jump, illegal and random instructions against a reference
// ======================================================================
`include "rv_exec_macros.svh"

module tb_rv_exec;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_exec_pkg::*;

    localparam int N_DIRECTED = 25;
    localparam int N_RANDOM   = 300;
    localparam int MARGIN     = 50;             // Reset and drain cycles

    logic        clk = 1'b0;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        busy;
    logic        retire_valid;
    retire_t     retire;

    retire_t     exp_q[$];                      // Expected records, oldest first
    string       name_q[$];
    int          cyc;                           // Rising edges so far
    int          accept_edge;
    bit          in_flight;
    int          sent;
    int          retired;
    int          pulses;                        // Retire strobes seen
    int          value_errors;
    int          protocol_errors;

    `include "rv_ref_model.svh"

    rv_exec_top dut0 (
        .clk, .rst_n, .instr_valid, .instr, .busy, .retire_valid, .retire
    );

    always #50 clk = ~clk;
    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_value(input string test, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        value_ok: assert (act === exp) else begin
            $display("FAILED %s %s: expected 0x%08h, actual 0x%08h", test, field, exp, act);
            value_errors++;
        end
    endtask

    task automatic compare_retire();
        retire_t exp;
        string   name;
        if (exp_q.size() == 0) begin
            $display("Retire record seen with no instruction outstanding");
            protocol_errors++;
        end else begin
            exp  = exp_q.pop_front();
            name = name_q.pop_front();
            if (retired == 0) begin             // First retire after reset
                check_value("reset_pc", "pc", `RV_RESET_PC, retire.pc);
                check_value("reset_pc", "next_pc", `RV_RESET_PC + 32'd4, retire.next_pc);
            end
            check_value(name, "pc", exp.pc, retire.pc);
            check_value(name, "next_pc", exp.next_pc, retire.next_pc);
            check_value(name, "rd", 32'(exp.rd), 32'(retire.rd));
            check_value(name, "rd_data", exp.rd_data, retire.rd_data);
            check_value(name, "reg_write", 32'(exp.reg_write), 32'(retire.reg_write));
            check_value(name, "illegal", 32'(exp.illegal), 32'(retire.illegal));
            retired++;
        end
    endtask

    // Outputs sampled mid-cycle, acceptance seen one edge ahead
    always @(negedge clk) begin
        if (rst_n) begin
            if (retire_valid) pulses++;
            if (in_flight && cyc < accept_edge + 3) begin
                busy_hold: assert (busy && !retire_valid) else begin
                    $display("Busy low or early retire at cycle %0d", cyc);
                    protocol_errors++;
                end
            end else if (in_flight) begin
                retire_timing: assert (retire_valid && !busy) else begin
                    $display("No retire 3 cycles after acceptance at edge %0d", accept_edge);
                    protocol_errors++;
                end
                compare_retire();
                in_flight = 1'b0;
            end else begin
                single_retire: assert (!retire_valid) else begin
                    $display("Retire pulse too long or unexpected at cycle %0d", cyc);
                    protocol_errors++;
                end
            end
            if (instr_valid && !busy) begin
                accept_edge = cyc + 1;          // Taken at the coming edge
                in_flight   = 1'b1;
            end
        end
    end

    task automatic send_instr(input logic [31:0] word, input string name);
        @(negedge clk);
        while (busy) @(negedge clk);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= word;
        exp_q.push_back(reference_step(word));
        name_q.push_back(name);
        sent++;
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    function automatic logic [31:0] random_instr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        rd  = 5'($urandom);
        rs1 = 5'($urandom);
        rs2 = 5'($urandom);
        f3  = 3'($urandom);
        imm = 12'($urandom);
        alt = ($urandom % 2 == 1) && (f3 == 3'd0 || f3 == 3'd5);   // SUB, SRA, SRAI
        if ($urandom % 2 == 1) return r_type({1'b0, alt, 5'b0}, rs2, rs1, f3, rd);
        if (f3 == 3'd1) imm = {7'h00, rs2};
        if (f3 == 3'd5) imm = {1'b0, alt, 5'b0, rs2};
        return i_type(imm, rs1, f3, rd, OPC_OP_IMM);
    endfunction

    initial begin
        void'($urandom(32'hc26d_2aa7));
        rst_n       <= 1'b0;
        instr_valid <= 1'b0;
        instr       <= '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        reset_idle: assert (!busy && !retire_valid) else begin
            $display("Busy or retire_valid high after reset");
            protocol_errors++;
        end
        send_instr(i_type(12'd5, 5'd0, 3'd0, 5'd1, OPC_OP_IMM), "addi_first");
        send_instr(i_type(12'hfff, 5'd0, 3'd0, 5'd2, OPC_OP_IMM), "addi_minus_one");
        send_instr(i_type(12'd1, 5'd0, 3'd0, 5'd3, OPC_OP_IMM), "addi_one");
        send_instr(i_type(12'd31, 5'd3, 3'd1, 5'd3, OPC_OP_IMM), "slli_31");
        send_instr(i_type(12'hfff, 5'd3, 3'd0, 5'd4, OPC_OP_IMM), "addi_max_pos");
        send_instr(r_type(7'h00, 5'd4, 5'd3, 3'd2, 5'd5), "slt_boundary");
        send_instr(r_type(7'h00, 5'd4, 5'd3, 3'd3, 5'd6), "sltu_boundary");
        send_instr(i_type(12'h000, 5'd2, 3'd2, 5'd7, OPC_OP_IMM), "slti_negative");
        send_instr(r_type(7'h20, 5'd1, 5'd0, 3'd0, 5'd8), "sub_underflow");
        send_instr(r_type(7'h00, 5'd0, 5'd3, 3'd5, 5'd9), "srl_0");
        send_instr(r_type(7'h20, 5'd0, 5'd3, 3'd5, 5'd10), "sra_0");
        send_instr(i_type(12'd31, 5'd3, 3'd5, 5'd11, OPC_OP_IMM), "srli_31");
        send_instr(i_type(12'h41f, 5'd3, 3'd5, 5'd12, OPC_OP_IMM), "srai_31");
        send_instr(i_type(12'h023, 5'd0, 3'd0, 5'd13, OPC_OP_IMM), "addi_amount");
        send_instr(r_type(7'h20, 5'd13, 5'd3, 3'd5, 5'd14), "sra_low_bits");
        send_instr(i_type(12'd7, 5'd1, 3'd0, 5'd0, OPC_OP_IMM), "write_x0");
        send_instr(u_type(20'h12345, 5'd15), "auipc");
        send_instr(j_type(21'd16, 5'd16), "jal_forward");
        send_instr(j_type(-21'sd8, 5'd17), "jal_backward");
        send_instr(i_type(12'h301, 5'd0, 3'd0, 5'd18, OPC_OP_IMM), "addi_target");
        send_instr(i_type(12'd4, 5'd18, 3'd0, 5'd19, OPC_JALR), "jalr_odd");
        send_instr(r_type(7'h01, 5'd2, 5'd1, 3'd0, 5'd20), "bad_funct7");
        send_instr(i_type(12'h401, 5'd1, 3'd1, 5'd21, OPC_OP_IMM), "bad_slli");
        send_instr(i_type(12'h123, 5'd1, 3'd0, 5'd22, 7'b0110111), "unknown_opcode");
        send_instr(i_type(12'd0, 5'd18, 3'd1, 5'd23, OPC_JALR), "bad_jalr");
        repeat (N_RANDOM) send_instr(random_instr(), "random");
        @(posedge clk);
        while (exp_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);              // Catch a stray retire pulse
        all_retired: assert (pulses == sent) else begin
            $display("%0d instructions sent but %0d retire pulses seen", sent, pulses);
            protocol_errors++;
        end
        $display("Errors: %0d value, %0d protocol, %0d instructions retired",
                 value_errors, protocol_errors, retired);
        if (value_errors + protocol_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Each instruction takes about 5 cycles with this driver
    initial begin
        repeat ((N_DIRECTED + N_RANDOM) * 6 + MARGIN) @(posedge clk);
        $display("Timeout at cycle %0d, not every instruction retired", cyc);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
